/* exe_stage.f */
+incdir+.
riscv_priv_pkg.sv
exe_ctrl_pkg.sv
exe_alu.sv
exe_branch_unit.sv
exe_csr_unit.sv
exe_trap_unit.sv
exe_stage.sv
exe_stage_assertions.sv
exe_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= exe_stage_tb
FLIST ?= exe_stage.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST)) exe_consts.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Testbench failed" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* exe_stage_tb.sv */
`include "exe_consts.svh"

module exe_stage_tb;
	import riscv_priv_pkg::*;
	import exe_ctrl_pkg::*;

	localparam int max_rows = 80;
	localparam int poll_limit = 20;

	// one issued instruction with its environment levels and expected results
	typedef struct packed
	{
		alu_op_t alu_op;
		wb_sel_t wb_sel;
		pc_sel_t pc_select;
		csr_op_t csr_op;
		priv_mode_t mode;
		logic [`XLEN-1:0] op_a, op_b, b_imm, j_imm, u_imm, pc, csr_imm, csr_rdata;
		logic [`REG_AW-1:0] rd, rs1;
		logic [`CSR_AW-1:0] csr_addr;
		logic we, btype, bneq, jal, jalr, csr_en;
		logic ecall, ebreak, i_mis, ill, mret, sret, uret;
		// bit 2 is M, bit 1 is S, bit 0 is U
		logic [2:0] tie, eie, timer, exp_irq;
		logic ext;
		logic [`XLEN-1:0] exp_wb, exp_csr_wb, exp_target, exp_pc_out, exp_u_imm;
		logic [`REG_AW-1:0] exp_rd;
		logic [`CSR_AW-1:0] exp_csr_addr;
		// mret, sret, uret from the top bit down
		logic [2:0] exp_ret;
		logic exp_we, exp_csr_we, exp_exc;
		trap_cause_t exp_cause;
		pc_sel_t exp_pc_sel;
	} row_t;

	logic clk, nrst;
	logic [`XLEN-1:0] op_a, op_b, b_imm, j_imm, u_imm, pc, csr_imm, csr_rdata;
	logic [`REG_AW-1:0] rd, rs1;
	alu_op_t alu_op;
	wb_sel_t wb_sel;
	pc_sel_t pc_select;
	csr_op_t csr_op;
	logic [`CSR_AW-1:0] csr_addr;
	logic we, btype, bneq, jal, jalr, csr_en;
	logic ecall, ebreak, i_misaligned, illegal_instr, mret, sret, uret;
	priv_mode_t current_mode;
	logic m_tie, s_tie, u_tie, m_eie, s_eie, u_eie;
	logic m_timer, s_timer, u_timer, external_interrupt;

	logic [`XLEN-1:0] wb_data, target, pc_out, u_imm_out, csr_wb;
	logic we_out, csr_we, exception, mret_out, sret_out, uret_out;
	logic m_interrupt, s_interrupt, u_interrupt;
	logic [`REG_AW-1:0] rd_out;
	logic [`CSR_AW-1:0] csr_wb_addr;
	pc_sel_t pc_select_out;
	trap_cause_t cause;

	row_t rows [max_rows];
	logic alive5 [max_rows];
	logic alive6 [max_rows];
	int n_rows = 0;
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	priv_mode_t cur_mode = mode_m;

	exe_stage DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic wait_edges(input int count);
		int goal;
		int polls;
		goal = cyc + count;
		polls = 0;
		while (cyc < goal && polls < poll_limit * count)
		begin
			#2;
			polls++;
		end
		if (cyc < goal)
		begin
			$display("Timeout: clock edge %0d never came", goal);
			$display("Testbench failed");
			$finish;
		end
	endtask

	task automatic check_word(input string name, input logic [`XLEN-1:0] got, exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_rd(input logic [`REG_AW-1:0] got, exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: rd_out is %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_csr_addr(input logic [`CSR_AW-1:0] got, exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: csr_wb_addr is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_cause(input trap_cause_t got, exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: cause is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_pc_sel(input pc_sel_t got, exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: pc_select_out is %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	function automatic logic [`XLEN-1:0] alu_ref(alu_op_t op, logic [`XLEN-1:0] a, b);
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_sll: return a << b[4:0];
			alu_slt: return {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: return {{(`XLEN-1){1'b0}}, a < b};
			alu_xor: return a ^ b;
			alu_srl: return a >> b[4:0];
			alu_sra: return $unsigned($signed(a) >>> b[4:0]);
			alu_or: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken_ref(row_t r);
		logic hit;
		case (r.alu_op)
			alu_sub: hit = r.op_a == r.op_b;
			alu_slt: hit = $signed(r.op_a) < $signed(r.op_b);
			alu_sltu: hit = r.op_a < r.op_b;
			default: return 1'b0;
		endcase
		return r.btype && (hit ^ r.bneq);
	endfunction

	function automatic logic [`XLEN-1:0] wb_ref(row_t r);
		case (r.wb_sel)
			wb_alu: return alu_ref(r.alu_op, r.op_a, r.op_b);
			wb_link: return r.pc + `XLEN'(`PC_STEP);
			wb_upper: return r.u_imm;
			wb_auipc: return r.pc + r.u_imm;
			wb_csr: return r.csr_rdata;
			default: return '0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] csr_ref(row_t r);
		logic [`XLEN-1:0] src;
		logic use_imm;
		use_imm = r.csr_op == csr_rwi || r.csr_op == csr_rsi || r.csr_op == csr_rci;
		src = use_imm ? r.csr_imm : r.op_a;
		case (r.csr_op)
			csr_rw, csr_rwi: return src;
			csr_rs, csr_rsi: return r.csr_rdata | src;
			csr_rc, csr_rci: return r.csr_rdata & ~src;
			default: return r.csr_rdata;
		endcase
	endfunction

	function automatic logic csr_illegal(row_t r, priv_mode_t mode);
		logic writes;
		writes = r.csr_op == csr_rw || r.csr_op == csr_rwi || r.rs1 != '0;
		return r.csr_en && (mode < r.csr_addr[9:8] || (&r.csr_addr[11:10] && writes));
	endfunction

	// trap outputs during cycle c, with row c-2 in stage 6
	task automatic expect_trap(input int c);
		row_t e;
		row_t s;
		logic ill;
		logic [2:0] tmr;
		trap_cause_t tc;
		e = rows[c];
		s = (c >= 2 && alive6[c-2]) ? rows[c-2] : '0;
		ill = s.ill || (c >= 2 && alive6[c-2] && csr_illegal(s, rows[c-1].mode));
		e.exp_irq[2] = e.eie[2] && e.ext;
		e.exp_irq[1] = e.mode != mode_m && e.eie[1] && e.ext;
		e.exp_irq[0] = e.mode == mode_u && e.eie[0] && e.ext;
		tmr = {e.tie[2] && e.timer[2], e.mode != mode_m && e.tie[1] && e.timer[1],
			e.mode == mode_u && e.tie[0] && e.timer[0]};
		tc = '0;
		tc.irq = |{e.exp_irq, tmr};
		if (e.exp_irq[2])
			tc.code = int_m_ext;
		else if (e.exp_irq[1])
			tc.code = int_s_ext;
		else if (tmr[2])
			tc.code = int_m_timer;
		else if (tmr[1])
			tc.code = int_s_timer;
		else if (e.exp_irq[0])
			tc.code = int_u_ext;
		else if (tmr[0])
			tc.code = int_u_timer;
		else if (s.i_mis)
			tc.code = exc_i_misaligned;
		else if (ill)
			tc.code = exc_illegal;
		else if (s.ecall)
		begin
			case (e.mode)
				mode_u: tc.code = exc_ecall_u;
				mode_s: tc.code = exc_ecall_s;
				default: tc.code = exc_ecall_m;
			endcase
		end
		else if (s.ebreak)
			tc.code = exc_breakpoint;
		e.exp_cause = tc;
		e.exp_exc = tc.irq || s.i_mis || ill || s.ecall || s.ebreak
			|| s.mret || s.sret || s.uret;
		rows[c] = e;
	endtask

	function automatic row_t base();
		row_t r;
		r = '0;
		r.mode = cur_mode;
		r.pc = $urandom() & ~`XLEN'(3);
		return r;
	endfunction

	task automatic push(input row_t r);
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic add_alu(input alu_op_t op, input int dst);
		row_t r;
		r = base();
		r.alu_op = op;
		r.op_a = $urandom();
		r.op_b = $urandom();
		r.rd = `REG_AW'(dst);
		r.we = 1'b1;
		push(r);
	endtask

	task automatic add_branch(input alu_op_t op, input logic ne, input logic [`XLEN-1:0] a, b);
		row_t r;
		r = base();
		r.alu_op = op;
		r.bneq = ne;
		r.btype = 1'b1;
		r.op_a = a;
		r.op_b = b;
		r.b_imm = `XLEN'(32'h40);
		r.pc_select = pc_redirect;
		push(r);
	endtask

	task automatic add_csr(input csr_op_t op, input logic [`CSR_AW-1:0] addr,
		input logic [`REG_AW-1:0] src_reg);
		row_t r;
		r = base();
		r.csr_op = op;
		r.csr_addr = addr;
		r.rs1 = src_reg;
		r.op_a = $urandom();
		r.csr_imm = `XLEN'(src_reg);
		r.csr_rdata = $urandom();
		r.csr_en = 1'b1;
		r.wb_sel = wb_csr;
		r.we = 1'b1;
		push(r);
	endtask

	task automatic add_irq(input priv_mode_t m, input logic [2:0] tie, eie, timer,
		input logic ext);
		row_t r;
		r = base();
		r.mode = m;
		r.tie = tie;
		r.eie = eie;
		r.timer = timer;
		r.ext = ext;
		push(r);
	endtask

	task automatic build_table();
		row_t r;
		for (int i = 0; i < 10; i++)
			add_alu(alu_op_t'(4'(i)), i + 1);
		add_branch(alu_sub, 1'b0, 32'h55, 32'h55);
		add_branch(alu_sub, 1'b0, 32'h55, 32'h56);
		add_branch(alu_sub, 1'b1, 32'h10, 32'h20);
		add_branch(alu_slt, 1'b0, 32'hffff_fff0, 32'h5);
		add_branch(alu_sltu, 1'b1, 32'hffff_fff0, 32'h5);
		add_branch(alu_sltu, 1'b0, 32'hffff_fff0, 32'h5);
		r = base();
		r.jal = 1'b1;
		r.j_imm = `XLEN'(32'h800);
		r.pc_select = pc_redirect;
		r.wb_sel = wb_link;
		r.we = 1'b1;
		push(r);
		r = base();
		r.jalr = 1'b1;
		r.op_a = $urandom();
		r.op_b = `XLEN'(32'h123);
		r.pc_select = pc_redirect;
		r.wb_sel = wb_link;
		r.we = 1'b1;
		push(r);
		for (int i = 0; i < 2; i++)
		begin
			r = base();
			r.wb_sel = i == 0 ? wb_upper : wb_auipc;
			r.u_imm = $urandom() & `XLEN'(32'hffff_f000);
			r.we = 1'b1;
			push(r);
		end
		add_csr(csr_rw, 12'h340, 5'd3);
		add_csr(csr_rs, 12'h340, 5'd4);
		add_csr(csr_rc, 12'h340, 5'd5);
		add_csr(csr_rwi, 12'h340, 5'd6);
		add_csr(csr_rsi, 12'h340, 5'd7);
		add_csr(csr_rci, 12'h340, 5'd8);
		add_csr(csr_rs, 12'hf14, 5'd0);
		add_csr(csr_rs, 12'hf14, 5'd9);
		add_alu(alu_add, 1);
		add_alu(alu_add, 2);
		cur_mode = mode_u;
		add_csr(csr_rs, 12'h300, 5'd0);
		add_alu(alu_add, 3);
		add_alu(alu_add, 4);
		for (int t = 0; t < 9; t++)
		begin
			// ecall is taken once in each mode
			cur_mode = t == 3 ? mode_u : t == 4 ? mode_s : mode_m;
			r = base();
			r.i_mis = t == 0;
			r.ill = t == 1;
			r.ebreak = t == 2;
			r.ecall = t >= 3 && t <= 5;
			r.mret = t == 6;
			r.sret = t == 7;
			r.uret = t == 8;
			push(r);
			add_alu(alu_xor, 5);
			add_alu(alu_or, 6);
		end
		add_irq(mode_m, 3'b111, 3'b111, 3'b111, 1'b1);
		add_irq(mode_s, 3'b010, 3'b010, 3'b110, 1'b1);
		add_irq(mode_s, 3'b110, 3'b000, 3'b110, 1'b0);
		add_irq(mode_u, 3'b011, 3'b001, 3'b011, 1'b0);
		add_irq(mode_u, 3'b001, 3'b001, 3'b001, 1'b1);
		add_irq(mode_u, 3'b001, 3'b000, 3'b001, 1'b1);
		add_irq(mode_m, 3'b011, 3'b011, 3'b011, 1'b1);
		add_alu(alu_sub, 7);
		add_alu(alu_add, 8);
		push(base());
		push(base());
	endtask

	task automatic fill_expected();
		row_t r;
		logic taken;
		logic [`XLEN-1:0] held_pc;
		for (int c = 0; c < n_rows; c++)
		begin
			if (c >= 2)
				alive6[c-2] = alive5[c-2] && !rows[c-1].exp_exc;
			expect_trap(c);
			alive5[c] = !rows[c].exp_exc;
		end
		// pc6 keeps its last value across a flush
		held_pc = '0;
		for (int k = 0; k < n_rows - 1; k++)
		begin
			r = rows[k];
			taken = taken_ref(r);
			r.exp_target = !alive5[k] ? '0 : r.jalr ? (r.op_a + r.op_b) & ~`XLEN'(1) :
				r.jal ? r.pc + r.j_imm : r.pc + r.b_imm;
			r.exp_pc_sel = (alive5[k] && (taken || r.jal || r.jalr)) ? r.pc_select : pc_seq;
			if (k < n_rows - 2)
			begin
				r.exp_we = alive6[k] && r.we;
				r.exp_wb = alive6[k] ? wb_ref(r) : '0;
				r.exp_csr_we = alive6[k] && r.csr_en && !csr_illegal(r, rows[k+1].mode);
				r.exp_csr_wb = alive6[k] ? csr_ref(r) : '0;
				r.exp_rd = alive6[k] ? r.rd : '0;
				r.exp_u_imm = alive6[k] ? r.u_imm : '0;
				r.exp_csr_addr = alive6[k] ? r.csr_addr : '0;
				r.exp_ret = alive6[k] ? {r.mret, r.sret, r.uret} : 3'b000;
				if (!rows[k+1].exp_exc)
					held_pc = alive5[k] ? r.pc : '0;
				r.exp_pc_out = held_pc;
			end
			rows[k] = r;
		end
	endtask

	task automatic drive(input row_t r);
		op_a = r.op_a;
		op_b = r.op_b;
		b_imm = r.b_imm;
		j_imm = r.j_imm;
		u_imm = r.u_imm;
		pc = r.pc;
		csr_imm = r.csr_imm;
		csr_rdata = r.csr_rdata;
		csr_addr = r.csr_addr;
		csr_op = r.csr_op;
		csr_en = r.csr_en;
		rd = r.rd;
		rs1 = r.rs1;
		alu_op = r.alu_op;
		wb_sel = r.wb_sel;
		we = r.we;
		pc_select = r.pc_select;
		btype = r.btype;
		bneq = r.bneq;
		jal = r.jal;
		jalr = r.jalr;
		ecall = r.ecall;
		ebreak = r.ebreak;
		i_misaligned = r.i_mis;
		illegal_instr = r.ill;
		mret = r.mret;
		sret = r.sret;
		uret = r.uret;
		current_mode = r.mode;
		{m_tie, s_tie, u_tie} = r.tie;
		{m_eie, s_eie, u_eie} = r.eie;
		{m_timer, s_timer, u_timer} = r.timer;
		external_interrupt = r.ext;
	endtask

	initial
	begin
		nrst = 1'b0;
		drive('0);
		void'($urandom(92131));
		build_table();
		fill_expected();
		wait_edges(10);
		nrst = 1'b1;
		for (int c = 0; c < n_rows; c++)
		begin
			drive(rows[c]);
			#4;
			if (c >= 1)
			begin
				check_word("target", target, rows[c-1].exp_target);
				check_pc_sel(pc_select_out, rows[c-1].exp_pc_sel);
			end
			if (c >= 2)
			begin
				check_word("wb_data", wb_data, rows[c-2].exp_wb);
				check_bit("we_out", we_out, rows[c-2].exp_we);
				check_rd(rd_out, rows[c-2].exp_rd);
				check_word("pc_out", pc_out, rows[c-2].exp_pc_out);
				check_word("u_imm_out", u_imm_out, rows[c-2].exp_u_imm);
				check_word("csr_wb", csr_wb, rows[c-2].exp_csr_wb);
				check_csr_addr(csr_wb_addr, rows[c-2].exp_csr_addr);
				check_bit("csr_we", csr_we, rows[c-2].exp_csr_we);
				check_bit("mret_out", mret_out, rows[c-2].exp_ret[2]);
				check_bit("sret_out", sret_out, rows[c-2].exp_ret[1]);
				check_bit("uret_out", uret_out, rows[c-2].exp_ret[0]);
			end
			check_bit("exception", exception, rows[c].exp_exc);
			check_cause(cause, rows[c].exp_cause);
			check_bit("m_interrupt", m_interrupt, rows[c].exp_irq[2]);
			check_bit("s_interrupt", s_interrupt, rows[c].exp_irq[1]);
			check_bit("u_interrupt", u_interrupt, rows[c].exp_irq[0]);
			wait_edges(1);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* exe_stage_assertions.sv */
module exe_stage_assertions
(
	input logic clk,
	input logic nrst,
	input logic we_out,
	input logic csr_we,
	input logic exception,
	input logic mret_out, sret_out, uret_out,
	input exe_ctrl_pkg::pc_sel_t pc_select_out,
	input logic u_interrupt,
	input riscv_priv_pkg::priv_mode_t current_mode,
	input riscv_priv_pkg::trap_cause_t cause
);
	import riscv_priv_pkg::*;
	import exe_ctrl_pkg::*;

	// registered controls stay low while in reset
	assert property (@(posedge clk) !nrst |-> !we_out && !csr_we && !mret_out && !sret_out
		&& !uret_out && pc_select_out == pc_seq)
		else $error("control output high during reset");

	// flushed slot writes nothing
	assert property (@(posedge clk) disable iff (!nrst) exception |=> !we_out && !csr_we)
		else $error("write enable high after a flush");

	assert property (@(posedge clk) u_interrupt |-> current_mode == mode_u)
		else $error("user interrupt outside user mode");

	assert property (@(posedge clk) !exception |-> cause == '0)
		else $error("cause set without a trap");

endmodule

bind exe_stage exe_stage_assertions u_assertions (.*);

/* exe_stage.sv */
`include "exe_consts.svh"

module exe_stage
(
	input logic clk,
	input logic nrst,

	// issue side
	input logic [`XLEN-1:0] op_a, op_b,
	input logic [`REG_AW-1:0] rd, rs1,
	input exe_ctrl_pkg::alu_op_t alu_op,
	input exe_ctrl_pkg::wb_sel_t wb_sel,
	input logic we,
	input logic [`XLEN-1:0] b_imm, j_imm, u_imm,
	input logic btype, bneq, jal, jalr,
	input logic [`XLEN-1:0] pc,
	input exe_ctrl_pkg::pc_sel_t pc_select,
	input exe_ctrl_pkg::csr_op_t csr_op,
	input logic [`CSR_AW-1:0] csr_addr,
	input logic [`XLEN-1:0] csr_imm, csr_rdata,
	input logic csr_en,
	input logic ecall, ebreak, i_misaligned, illegal_instr,
	input logic mret, sret, uret,

	// environment
	input riscv_priv_pkg::priv_mode_t current_mode,
	input logic m_tie, s_tie, u_tie,
	input logic m_eie, s_eie, u_eie,
	input logic m_timer, s_timer, u_timer,
	input logic external_interrupt,

	output logic [`XLEN-1:0] wb_data,
	output logic we_out,
	output logic [`REG_AW-1:0] rd_out,
	output logic [`XLEN-1:0] target,
	output exe_ctrl_pkg::pc_sel_t pc_select_out,
	output logic [`XLEN-1:0] pc_out, u_imm_out,
	output logic [`XLEN-1:0] csr_wb,
	output logic [`CSR_AW-1:0] csr_wb_addr,
	output logic csr_we,
	output riscv_priv_pkg::trap_cause_t cause,
	output logic exception,
	output logic mret_out, sret_out, uret_out,
	output logic m_interrupt, s_interrupt, u_interrupt
);
	import exe_ctrl_pkg::*;

	// stage 5
	alu_op_t alu_op5;
	wb_sel_t wb_sel5;
	pc_sel_t pc_select5;
	csr_op_t csr_op5;
	logic [12:0] flags5;
	logic we5, btype5, bneq5, jal5, jalr5, csr_en5;
	logic ecall5, ebreak5, i_mis5, illegal5, mret5, sret5, uret5;
	logic [`XLEN-1:0] op_a5, op_b5, b_imm5, j_imm5, u_imm5, pc5, csr_imm5, csr_rdata5;
	logic [`REG_AW-1:0] rd5, rs1_5;
	logic [`CSR_AW-1:0] csr_addr5;
	logic [`XLEN-1:0] alu_res5, csr_new5;
	logic btaken5, illegal_csr5;

	// stage 6
	wb_sel_t wb_sel6;
	logic [8:0] flags6;
	logic we6, csr_we6, i_mis6, illegal6, ecall6, ebreak6, mret6, sret6, uret6;
	logic [`XLEN-1:0] alu_res6, u_imm6, auipc6, pc6, csr_old6, csr_new6;
	logic [`REG_AW-1:0] rd6;
	logic [`CSR_AW-1:0] csr_addr6;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			flags5 <= '0;
			alu_op5 <= alu_add;
			wb_sel5 <= wb_alu;
			pc_select5 <= pc_seq;
			csr_op5 <= csr_op_t'(3'd0);
		end
		else if (exception)
		begin
			// a pending trap also drops the instruction being issued
			flags5 <= '0;
			alu_op5 <= alu_add;
			wb_sel5 <= wb_alu;
			pc_select5 <= pc_seq;
			csr_op5 <= csr_op_t'(3'd0);
		end
		else
		begin
			flags5 <= {we, btype, bneq, jal, jalr, csr_en, ecall, ebreak,
				i_misaligned, illegal_instr, mret, sret, uret};
			alu_op5 <= alu_op;
			wb_sel5 <= wb_sel;
			pc_select5 <= pc_select;
			csr_op5 <= csr_op;
		end
	end

	assign {we5, btype5, bneq5, jal5, jalr5, csr_en5, ecall5, ebreak5,
		i_mis5, illegal5, mret5, sret5, uret5} = flags5;

	always_ff @(posedge clk)
	begin
		op_a5 <= exception ? '0 : op_a;
		op_b5 <= exception ? '0 : op_b;
		rd5 <= exception ? '0 : rd;
		rs1_5 <= exception ? '0 : rs1;
		b_imm5 <= exception ? '0 : b_imm;
		j_imm5 <= exception ? '0 : j_imm;
		u_imm5 <= exception ? '0 : u_imm;
		pc5 <= exception ? '0 : pc;
		csr_addr5 <= exception ? '0 : csr_addr;
		csr_imm5 <= exception ? '0 : csr_imm;
		csr_rdata5 <= exception ? '0 : csr_rdata;
	end

	exe_alu u_alu
	(
		.alu_op (alu_op5),
		.operand_a (op_a5),
		.operand_b (op_b5),
		.btype (btype5),
		.bneq (bneq5),
		.result (alu_res5),
		.btaken (btaken5)
	);

	// op_b carries the I immediate for jalr
	exe_branch_unit u_branch
	(
		.pc (pc5),
		.operand_a (op_a5),
		.b_imm (b_imm5),
		.j_imm (j_imm5),
		.i_imm (op_b5),
		.btaken (btaken5),
		.jal (jal5),
		.jalr (jalr5),
		.pc_select (pc_select5),
		.target (target),
		.pc_select_out (pc_select_out)
	);

	exe_csr_unit u_csr
	(
		.csr_op (csr_op5),
		.csr_en (csr_en5),
		.rs1 (rs1_5),
		.rs1_val (op_a5),
		.imm (csr_imm5),
		.csr_old (csr_rdata5),
		.csr_addr (csr_addr5),
		.current_mode (current_mode),
		.csr_new (csr_new5),
		.illegal_csr (illegal_csr5)
	);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			flags6 <= '0;
			wb_sel6 <= wb_alu;
		end
		else if (exception)
		begin
			flags6 <= '0;
			wb_sel6 <= wb_alu;
		end
		else
		begin
			// an illegal access never reaches the CSR file
			flags6 <= {we5, csr_en5 && !illegal_csr5, i_mis5, illegal5 || illegal_csr5,
				ecall5, ebreak5, mret5, sret5, uret5};
			wb_sel6 <= wb_sel5;
		end
	end

	assign {we6, csr_we6, i_mis6, illegal6, ecall6, ebreak6, mret6, sret6, uret6} = flags6;

	always_ff @(posedge clk)
	begin
		alu_res6 <= exception ? '0 : alu_res5;
		rd6 <= exception ? '0 : rd5;
		u_imm6 <= exception ? '0 : u_imm5;
		auipc6 <= exception ? '0 : pc5 + u_imm5;
		csr_old6 <= exception ? '0 : csr_rdata5;
		csr_new6 <= exception ? '0 : csr_new5;
		csr_addr6 <= exception ? '0 : csr_addr5;
		// trapping pc stays for the epc write
		if (!exception)
			pc6 <= pc5;
	end

	exe_trap_unit u_trap
	(
		.current_mode (current_mode),
		.m_tie (m_tie),
		.s_tie (s_tie),
		.u_tie (u_tie),
		.m_eie (m_eie),
		.s_eie (s_eie),
		.u_eie (u_eie),
		.m_timer (m_timer),
		.s_timer (s_timer),
		.u_timer (u_timer),
		.external_interrupt (external_interrupt),
		.i_misaligned (i_mis6),
		.illegal (illegal6),
		.ecall (ecall6),
		.ebreak (ebreak6),
		.xret (mret6 || sret6 || uret6),
		.cause (cause),
		.exception (exception),
		.m_interrupt (m_interrupt),
		.s_interrupt (s_interrupt),
		.u_interrupt (u_interrupt)
	);

	always_comb
	begin
		case (wb_sel6)
			wb_alu: wb_data = alu_res6;
			wb_link: wb_data = pc6 + `XLEN'(`PC_STEP);
			wb_upper: wb_data = u_imm6;
			wb_auipc: wb_data = auipc6;
			wb_csr: wb_data = csr_old6;
			default: wb_data = '0;
		endcase
	end

	assign we_out = we6;
	assign rd_out = rd6;
	assign pc_out = pc6;
	assign u_imm_out = u_imm6;
	assign csr_wb = csr_new6;
	assign csr_wb_addr = csr_addr6;
	assign csr_we = csr_we6;
	assign mret_out = mret6;
	assign sret_out = sret6;
	assign uret_out = uret6;

endmodule

/* exe_trap_unit.sv */
`include "exe_consts.svh"

module exe_trap_unit
(
	input riscv_priv_pkg::priv_mode_t current_mode,
	input logic m_tie, s_tie, u_tie,
	input logic m_eie, s_eie, u_eie,
	input logic m_timer, s_timer, u_timer,
	input logic external_interrupt,
	input logic i_misaligned,
	input logic illegal,
	input logic ecall,
	input logic ebreak,
	input logic xret,
	output riscv_priv_pkg::trap_cause_t cause,
	output logic exception,
	output logic m_interrupt, s_interrupt, u_interrupt
);
	import riscv_priv_pkg::*;

	logic not_m;
	logic is_u;
	logic m_tmr, s_tmr, u_tmr;
	logic any_irq;

	assign not_m = current_mode != mode_m;
	assign is_u = current_mode == mode_u;

	// timers
	assign m_tmr = m_tie && m_timer;
	assign s_tmr = not_m && s_tie && s_timer;
	assign u_tmr = is_u && u_tie && u_timer;

	// external line seen at each level
	assign m_interrupt = m_eie && external_interrupt;
	assign s_interrupt = not_m && s_eie && external_interrupt;
	assign u_interrupt = is_u && u_eie && external_interrupt;

	assign any_irq = m_interrupt || s_interrupt || u_interrupt || m_tmr || s_tmr || u_tmr;

	// xret flushes too but has no cause
	assign exception = any_irq || i_misaligned || illegal || ecall || ebreak || xret;

	// highest priority first
	always_comb
	begin
		cause = '0;
		cause.irq = any_irq;
		if (m_interrupt)
			cause.code = int_m_ext;
		else if (s_interrupt)
			cause.code = int_s_ext;
		else if (m_tmr)
			cause.code = int_m_timer;
		else if (s_tmr)
			cause.code = int_s_timer;
		else if (u_interrupt)
			cause.code = int_u_ext;
		else if (u_tmr)
			cause.code = int_u_timer;
		else if (i_misaligned)
			cause.code = exc_i_misaligned;
		else if (illegal)
			cause.code = exc_illegal;
		else if (ecall)
		begin
			case (current_mode)
				mode_u: cause.code = exc_ecall_u;
				mode_s: cause.code = exc_ecall_s;
				default: cause.code = exc_ecall_m;
			endcase
		end
		else if (ebreak)
			cause.code = exc_breakpoint;
	end

endmodule

/* exe_csr_unit.sv */
`include "exe_consts.svh"

module exe_csr_unit
(
	input exe_ctrl_pkg::csr_op_t csr_op,
	input logic csr_en,
	input logic [`REG_AW-1:0] rs1,
	input logic [`XLEN-1:0] rs1_val,
	input logic [`XLEN-1:0] imm,
	input logic [`XLEN-1:0] csr_old,
	input logic [`CSR_AW-1:0] csr_addr,
	input riscv_priv_pkg::priv_mode_t current_mode,
	output logic [`XLEN-1:0] csr_new,
	output logic illegal_csr
);
	import exe_ctrl_pkg::*;

	logic [`XLEN-1:0] src;
	logic writes;
	logic low_priv;
	logic read_only;

	// funct3 bit 2 selects the zero-extended uimm
	assign src = csr_op[2] ? imm : rs1_val;

	always_comb
	begin
		case (csr_op)
			csr_rw, csr_rwi: csr_new = src;
			csr_rs, csr_rsi: csr_new = csr_old | src;
			csr_rc, csr_rci: csr_new = csr_old & ~src;
			default: csr_new = csr_old;
		endcase
	end

	// set and clear with a zero source field only read
	assign writes = (csr_op == csr_rw) || (csr_op == csr_rwi) || (rs1 != '0);

	// bits 9:8 give the lowest mode allowed to touch the register
	assign low_priv = 2'(current_mode) < csr_addr[9:8];

	// bits 11:10 both set marks a read-only register
	assign read_only = &csr_addr[11:10];

	assign illegal_csr = csr_en && (low_priv || (read_only && writes));

endmodule

/* exe_branch_unit.sv */
`include "exe_consts.svh"

module exe_branch_unit
(
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] operand_a,
	input logic [`XLEN-1:0] b_imm,
	input logic [`XLEN-1:0] j_imm,
	input logic [`XLEN-1:0] i_imm,
	input logic btaken,
	input logic jal,
	input logic jalr,
	input exe_ctrl_pkg::pc_sel_t pc_select,
	output logic [`XLEN-1:0] target,
	output exe_ctrl_pkg::pc_sel_t pc_select_out
);
	import exe_ctrl_pkg::*;

	logic [`XLEN-1:0] jalr_sum;

	assign jalr_sum = operand_a + i_imm;

	always_comb
	begin
		// jalr drops bit 0 of the sum
		if (jalr)
			target = {jalr_sum[`XLEN-1:1], 1'b0};
		else if (jal)
			target = pc + j_imm;
		else
			target = pc + b_imm;
	end

	// redirect only on a taken branch or a jump
	assign pc_select_out = (btaken || jal || jalr) ? pc_select : pc_seq;

endmodule

/* exe_alu.sv */
`include "exe_consts.svh"

module exe_alu
(
	input exe_ctrl_pkg::alu_op_t alu_op,
	input logic [`XLEN-1:0] operand_a,
	input logic [`XLEN-1:0] operand_b,
	input logic btype,
	input logic bneq,
	output logic [`XLEN-1:0] result,
	output logic btaken
);
	import exe_ctrl_pkg::*;

	localparam int shamt_w = $clog2(`XLEN);

	logic [shamt_w-1:0] shamt;
	logic taken;

	assign shamt = operand_b[shamt_w-1:0];

	always_comb
	begin
		case (alu_op)
			alu_add: result = operand_a + operand_b;
			alu_sub: result = operand_a - operand_b;
			alu_sll: result = operand_a << shamt;
			alu_slt: result = `XLEN'($signed(operand_a) < $signed(operand_b));
			alu_sltu: result = `XLEN'(operand_a < operand_b);
			alu_xor: result = operand_a ^ operand_b;
			alu_srl: result = operand_a >> shamt;
			alu_sra: result = $unsigned($signed(operand_a) >>> shamt);
			alu_or: result = operand_a | operand_b;
			alu_and: result = operand_a & operand_b;
			default: result = '0;
		endcase
	end

	// sub gives beq, the slt forms give blt and bltu
	// bneq flips the sense for bne, bge and bgeu
	always_comb
	begin
		case (alu_op)
			alu_sub: taken = (operand_a == operand_b) ^ bneq;
			alu_slt, alu_sltu: taken = (|result) ^ bneq;
			default: taken = 1'b0;
		endcase
	end

	assign btaken = btype && taken;

endmodule

/* exe_ctrl_pkg.sv */
package exe_ctrl_pkg;

	typedef enum logic [3:0]
	{
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_t;

	// unused encodings are left as gaps
	typedef enum logic [2:0]
	{
		wb_alu = 3'd0,
		wb_link = 3'd1,
		wb_upper = 3'd3,
		wb_auipc = 3'd5,
		wb_csr = 3'd6
	} wb_sel_t;

	// same as funct3 of the system opcode
	typedef enum logic [2:0]
	{
		csr_rw = 3'd1,
		csr_rs = 3'd2,
		csr_rc = 3'd3,
		csr_rwi = 3'd5,
		csr_rsi = 3'd6,
		csr_rci = 3'd7
	} csr_op_t;

	typedef enum logic [1:0]
	{
		pc_seq = 2'd0,
		pc_redirect = 2'd1
	} pc_sel_t;

endpackage

/* riscv_priv_pkg.sv */
`include "exe_consts.svh"

package riscv_priv_pkg;

	localparam int code_w = `XLEN - 1;

	// 2'b10 is reserved
	typedef enum logic [1:0]
	{
		mode_u = 2'b00,
		mode_s = 2'b01,
		mode_m = 2'b11
	} priv_mode_t;

	// synchronous causes
	typedef enum logic [code_w-1:0]
	{
		exc_i_misaligned = code_w'(0),
		exc_illegal = code_w'(2),
		exc_breakpoint = code_w'(3),
		exc_ecall_u = code_w'(8),
		exc_ecall_s = code_w'(9),
		exc_ecall_m = code_w'(11)
	} exc_code_t;

	// asynchronous causes
	typedef enum logic [code_w-1:0]
	{
		int_u_timer = code_w'(4),
		int_s_timer = code_w'(5),
		int_m_timer = code_w'(7),
		int_u_ext = code_w'(8),
		int_s_ext = code_w'(9),
		int_m_ext = code_w'(11)
	} int_code_t;

	// mcause layout
	typedef struct packed
	{
		logic irq;
		logic [code_w-1:0] code;
	} trap_cause_t;

endpackage

/* exe_consts.svh */
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// datapath and address widths
`define XLEN 32
`define REG_AW 5
`define CSR_AW 12

// link address step of one instruction
`define PC_STEP 4

`endif
